// File: verilog/sys_pkg.sv
`default_nettype none

package sys_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	localparam logic [ADDR_W-1:0] HRAM_BASE = 16'hff80;
	localparam int HRAM_DEPTH = 127;
	localparam int BOOT_DEPTH = 256;

	localparam logic [ADDR_W-1:0] REG_DIV      = 16'hff04;
	localparam logic [ADDR_W-1:0] REG_TIMA     = 16'hff05;
	localparam logic [ADDR_W-1:0] REG_TMA      = 16'hff06;
	localparam logic [ADDR_W-1:0] REG_TAC      = 16'hff07;
	localparam logic [ADDR_W-1:0] REG_IF       = 16'hff0f;
	localparam logic [ADDR_W-1:0] REG_BOOT_OFF = 16'hff50;
	localparam logic [ADDR_W-1:0] REG_IE       = 16'hffff;

	localparam int INT_TIMER = 2; // IF bit of the timer request

	typedef enum logic [2:0] {
		REG_NONE,
		REG_BOOT,
		REG_HRAM,
		REG_TIMER,
		REG_INTR,
		REG_EXT
	} region_t;

	// TAC[1:0] rates, DIV bits 9, 3, 5, 7
	typedef enum logic [1:0] {
		CLK_1024,
		CLK_16,
		CLK_64,
		CLK_256
	} tac_clk_t;

endpackage

`default_nettype wire

// File: verilog/cpu_port_if.sv
`timescale 1ns/1ns
`default_nettype none

interface cpu_port_if import sys_pkg::*; ();

	logic [7:0]        addr; // Low address byte
	logic [DATA_W-1:0] wdata;
	logic              wr;
	logic              rd;
	logic [DATA_W-1:0] rdata;

	modport master(output addr, output wdata, output wr, output rd, input rdata);

	modport slave(input addr, input wdata, input wr, input rd, output rdata);

endinterface

`default_nettype wire

// File: verilog/sys_decode.sv
`timescale 1ns/1ns
`default_nettype none

module sys_decode import sys_pkg::*; (
		input  logic              clk,
		input  logic              rst,
		input  logic [ADDR_W-1:0] a,
		input  logic [DATA_W-1:0] wdata,
		input  logic              wr,
		input  logic              rd,
		output logic [DATA_W-1:0] rdata,

		output logic              ext_cs,
		output logic              ext_wr,
		output logic              ext_rd,
		input  logic [DATA_W-1:0] ext_rdata,

		cpu_port_if.master        boot_p,
		cpu_port_if.master        hram_p,
		cpu_port_if.master        timer_p,
		cpu_port_if.master        intr_p
	);

	region_t region;
	region_t rd_region;
	logic    boot_off;
	logic    ffxx;

	assign ffxx = &a[15:8];

	always_comb begin
		if (!boot_off && a < BOOT_DEPTH)
			region = REG_BOOT;
		else if (!ffxx)
			region = REG_EXT;
		else if (a >= HRAM_BASE && a != REG_IE)
			region = REG_HRAM;
		else if (a[15:2] == REG_DIV[15:2])
			region = REG_TIMER; // FF04-FF07
		else if (a == REG_IF || a == REG_IE)
			region = REG_INTR;
		else
			region = REG_NONE;
	end

	// Sticky until reset
	always_ff @(posedge clk) begin
		if (rst)
			boot_off <= 1'b0;
		else if (wr && a == REG_BOOT_OFF && wdata[0])
			boot_off <= 1'b1;
	end

	assign ext_cs = (region == REG_EXT);
	assign ext_wr = ext_cs && wr;
	assign ext_rd = ext_cs && rd;

	assign boot_p.addr  = a[7:0];
	assign boot_p.wdata = wdata;
	assign boot_p.wr    = wr && (region == REG_BOOT);
	assign boot_p.rd    = rd && (region == REG_BOOT);

	assign hram_p.addr  = a[7:0];
	assign hram_p.wdata = wdata;
	assign hram_p.wr    = wr && (region == REG_HRAM);
	assign hram_p.rd    = rd && (region == REG_HRAM);

	assign timer_p.addr  = a[7:0];
	assign timer_p.wdata = wdata;
	assign timer_p.wr    = wr && (region == REG_TIMER);
	assign timer_p.rd    = rd && (region == REG_TIMER);

	assign intr_p.addr  = a[7:0];
	assign intr_p.wdata = wdata;
	assign intr_p.wr    = wr && (region == REG_INTR);
	assign intr_p.rd    = rd && (region == REG_INTR);

	// Slave data arrives one cycle after rd
	always_ff @(posedge clk) begin
		if (rst)
			rd_region <= REG_NONE;
		else if (rd)
			rd_region <= region;
	end

	always_comb begin
		case (rd_region)
			REG_BOOT:  rdata = boot_p.rdata;
			REG_HRAM:  rdata = hram_p.rdata;
			REG_TIMER: rdata = timer_p.rdata;
			REG_INTR:  rdata = intr_p.rdata;
			REG_EXT:   rdata = ext_rdata;
			default:   rdata = '1; // Open bus in FF00-FF7F
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/hram.sv
`timescale 1ns/1ns
`default_nettype none

module hram import sys_pkg::*; (
		input logic       clk,
		cpu_port_if.slave port
	);

	logic [DATA_W-1:0] mem [HRAM_DEPTH];
	logic [7:0]        offs;

	assign offs = port.addr - HRAM_BASE[7:0]; // FF80 maps to word 0

	always_ff @(posedge clk) begin
		if (port.wr)
			mem[offs[6:0]] <= port.wdata;
		if (port.rd)
			port.rdata <= mem[offs[6:0]];
	end

endmodule

`default_nettype wire

// File: verilog/boot_rom.sv
`timescale 1ns/1ns
`default_nettype none

module boot_rom import sys_pkg::*; (
		input logic       clk,
		cpu_port_if.slave port
	);

	logic [DATA_W-1:0] rom [BOOT_DEPTH];

	initial begin
		$readmemh("verilog/boot.hex", rom);
	end

	// Read only, write strobes have no effect
	always_ff @(posedge clk) begin
		if (port.rd)
			port.rdata <= rom[port.addr];
	end

endmodule

`default_nettype wire

// File: verilog/timer.sv
`timescale 1ns/1ns
`default_nettype none

module timer import sys_pkg::*; (
		input  logic      clk,
		input  logic      rst,
		cpu_port_if.slave port,
		output logic      irq
	);

	logic [15:0]       div;
	logic [DATA_W-1:0] tima;
	logic [DATA_W-1:0] tma;
	logic [2:0]        tac;
	logic              sel_bit;
	logic              tick_in;
	logic              tick_q;
	logic              reload;

	always_comb begin
		case (tac_clk_t'(tac[1:0]))
			CLK_1024: sel_bit = div[9];
			CLK_16:   sel_bit = div[3];
			CLK_64:   sel_bit = div[5];
			default:  sel_bit = div[7];
		endcase
	end

	assign tick_in = tac[2] && sel_bit;

	always_ff @(posedge clk) begin
		if (rst) begin
			div    <= '0;
			tima   <= '0;
			tma    <= '0;
			tac    <= '0;
			tick_q <= 1'b0;
			reload <= 1'b0;
			irq    <= 1'b0;
		end else begin
			tick_q <= tick_in;
			reload <= 1'b0;
			irq    <= 1'b0;
			if (port.wr && port.addr == REG_DIV[7:0])
				div <= '0;
			else
				div <= div + 16'd1;
			if (port.wr && port.addr == REG_TMA[7:0])
				tma <= port.wdata;
			if (port.wr && port.addr == REG_TAC[7:0])
				tac <= port.wdata[2:0];
			if (reload) begin
				tima <= tma; // One cycle after wrap
				irq  <= 1'b1;
			end else if (port.wr && port.addr == REG_TIMA[7:0])
				tima <= port.wdata;
			else if (tick_q && !tick_in)
				{reload, tima} <= {1'b0, tima} + 9'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (port.rd) begin
			case (port.addr)
				REG_DIV[7:0]:  port.rdata <= div[15:8];
				REG_TIMA[7:0]: port.rdata <= tima;
				REG_TMA[7:0]:  port.rdata <= tma;
				REG_TAC[7:0]:  port.rdata <= {5'b11111, tac};
				default:       port.rdata <= '1;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/int_flags.sv
`timescale 1ns/1ns
`default_nettype none

module int_flags import sys_pkg::*; (
		input  logic      clk,
		input  logic      rst,
		cpu_port_if.slave port,
		input  logic      timer_irq
	);

	logic [4:0]        if_q;
	logic [DATA_W-1:0] ie_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			if_q <= '0;
			ie_q <= '0;
		end else begin
			if (port.wr && port.addr == REG_IF[7:0])
				if_q <= port.wdata[4:0];
			if (timer_irq)
				if_q[INT_TIMER] <= 1'b1; // Beats a CPU write
			if (port.wr && port.addr == REG_IE[7:0])
				ie_q <= port.wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (port.rd) begin
			if (port.addr == REG_IF[7:0])
				port.rdata <= {3'b111, if_q};
			else if (port.addr == REG_IE[7:0])
				port.rdata <= ie_q;
			else
				port.rdata <= '1;
		end
	end

endmodule

`default_nettype wire

// File: verilog/sys_top.sv
`timescale 1ns/1ns
`default_nettype none

module sys_top import sys_pkg::*; (
		input  logic              clk,
		input  logic              rst,
		input  logic [ADDR_W-1:0] a,
		input  logic [DATA_W-1:0] wdata,
		input  logic              wr,
		input  logic              rd,
		output logic [DATA_W-1:0] rdata,
		output logic              ext_cs,
		output logic              ext_wr,
		output logic              ext_rd,
		input  logic [DATA_W-1:0] ext_rdata
	);

	logic timer_irq;

	cpu_port_if boot_bus();
	cpu_port_if hram_bus();
	cpu_port_if timer_bus();
	cpu_port_if intr_bus();

	sys_decode u_decode (
		.clk       (clk),
		.rst       (rst),
		.a         (a),
		.wdata     (wdata),
		.wr        (wr),
		.rd        (rd),
		.rdata     (rdata),
		.ext_cs    (ext_cs),
		.ext_wr    (ext_wr),
		.ext_rd    (ext_rd),
		.ext_rdata (ext_rdata),
		.boot_p    (boot_bus),
		.hram_p    (hram_bus),
		.timer_p   (timer_bus),
		.intr_p    (intr_bus)
	);

	boot_rom u_boot_rom (.clk(clk), .port(boot_bus));

	hram u_hram (.clk(clk), .port(hram_bus));

	timer u_timer (
		.clk  (clk),
		.rst  (rst),
		.port (timer_bus),
		.irq  (timer_irq)
	);

	int_flags u_int_flags (
		.clk       (clk),
		.rst       (rst),
		.port      (intr_bus),
		.timer_irq (timer_irq)
	);

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
		output logic clk,
		output logic rst
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk); // Four reset cycles
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

// File: tests/sys_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module sys_assertions (
		input logic       clk,
		input logic       rst,
		input logic       wr,
		input logic       rd,
		input logic       boot_off,
		input logic [4:0] port_wr, // {ext, intr, timer, hram, boot}
		input logic [4:0] port_rd
	);

	strobe_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0({port_wr, port_rd}))
		else $error("more than one slave strobe in a cycle");

	no_stray_wr: assert property (@(posedge clk) disable iff (rst) |port_wr |-> wr)
		else $error("slave write strobe without a CPU write");

	no_stray_rd: assert property (@(posedge clk) disable iff (rst) |port_rd |-> rd)
		else $error("slave read strobe without a CPU read");

	// Only a reset may unlatch
	boot_sticky: assert property (@(posedge clk) $fell(boot_off) |-> $past(rst))
		else $error("boot ROM disable latch cleared without reset");

endmodule

`default_nettype wire

// File: tests/sys_tb.sv
`timescale 1ns/1ns
`default_nettype none

module sys_tb import sys_pkg::*; ();

	logic        clk;
	logic        rst;
	logic [15:0] a;
	logic [7:0]  wdata;
	logic        wr;
	logic        rd;
	logic [7:0]  rdata;
	logic        ext_cs;
	logic        ext_wr;
	logic        ext_rd;
	logic [7:0]  ext_rdata;

	logic [31:0] lfsr;
	logic [7:0]  boot_img [256];
	logic [7:0]  shadow_hram [127];
	logic        hram_valid [127];
	logic        shadow_boot_off;
	logic [7:0]  shadow_tma;
	logic [2:0]  shadow_tac;
	logic [4:0]  shadow_if;
	logic [7:0]  shadow_ie;
	logic        timer_used; // IF bit 2 may be set by hardware
	logic        pend_valid;
	logic [15:0] pend_addr;
	logic [7:0]  pend_exp;
	logic [7:0]  pend_mask;
	logic [7:0]  last_rdata;
	logic        exp_ext;
	int          cycles = 0;
	int          reads_checked = 0;
	int          data_errors = 0;
	int          strobe_errors = 0;
	int          other_errors = 0;

	tb_clock u_clock (.clk(clk), .rst(rst));

	sys_top uut (
		.clk       (clk),
		.rst       (rst),
		.a         (a),
		.wdata     (wdata),
		.wr        (wr),
		.rd        (rd),
		.rdata     (rdata),
		.ext_cs    (ext_cs),
		.ext_wr    (ext_wr),
		.ext_rd    (ext_rd),
		.ext_rdata (ext_rdata)
	);

	bind sys_decode sys_assertions u_sva (
		.clk      (clk),
		.rst      (rst),
		.wr       (wr),
		.rd       (rd),
		.boot_off (boot_off),
		.port_wr  ({ext_wr, intr_p.wr, timer_p.wr, hram_p.wr, boot_p.wr}),
		.port_rd  ({ext_rd, intr_p.rd, timer_p.rd, hram_p.rd, boot_p.rd})
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic expect_ext(input logic [15:0] addr);
		return (shadow_boot_off || addr >= 16'h0100) && addr[15:8] != 8'hff;
	endfunction

	function automatic logic [7:0] ref_read(input logic [15:0] addr);
		if (!shadow_boot_off && addr < 16'h0100)
			return boot_img[addr[7:0]];
		if (addr[15:8] != 8'hff)
			return addr[7:0] ^ 8'ha5; // External bus model
		if (addr >= HRAM_BASE && addr != REG_IE)
			return shadow_hram[addr[6:0]]; // FF80 is word 0
		case (addr)
			REG_TMA: return shadow_tma;
			REG_TAC: return {5'b11111, shadow_tac};
			REG_IF:  return {3'b111, shadow_if};
			REG_IE:  return shadow_ie;
			default: return 8'hff;
		endcase
	endfunction

	function automatic logic [7:0] checked_bits(input logic [15:0] addr);
		if (addr[15:8] != 8'hff)
			return 8'hff;
		if (addr >= HRAM_BASE && addr != REG_IE)
			return hram_valid[addr[6:0]] ? 8'hff : 8'h00;
		if (addr == REG_DIV || addr == REG_TIMA)
			return 8'h00; // Free running, tolerance checks instead
		if (addr == REG_IF && timer_used && !shadow_if[INT_TIMER])
			return 8'hfb;
		return 8'hff;
	endfunction

	task automatic store_byte(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		a     <= addr;
		wdata <= data;
		wr    <= 1'b1;
		@(posedge clk);
		wr <= 1'b0;
	endtask

	task automatic load_byte(input logic [15:0] addr, output logic [7:0] data);
		int n;
		n = reads_checked;
		@(posedge clk);
		a  <= addr;
		rd <= 1'b1;
		@(posedge clk);
		rd <= 1'b0;
		wait (reads_checked != n);
		data = last_rdata;
	endtask

	initial begin
		$readmemh("verilog/boot.hex", boot_img);
		for (int i = 0; i < 127; i++)
			hram_valid[i] = 1'b0;
	end

	always @(posedge clk)
		cycles <= cycles + 1;

	always @(posedge clk) begin
		if (ext_rd)
			ext_rdata <= a[7:0] ^ 8'ha5;
	end

	// Shadow registers follow the CPU writes
	always @(posedge clk) begin
		if (rst) begin
			shadow_boot_off <= 1'b0;
			shadow_tma      <= '0;
			shadow_tac      <= '0;
			shadow_if       <= '0;
			shadow_ie       <= '0;
			timer_used      <= 1'b0;
		end else if (wr) begin
			if (a == REG_BOOT_OFF && wdata[0])
				shadow_boot_off <= 1'b1;
			if (a >= HRAM_BASE && a != REG_IE) begin
				shadow_hram[a[6:0]] <= wdata;
				hram_valid[a[6:0]]  <= 1'b1;
			end
			if (a == REG_TMA)
				shadow_tma <= wdata;
			if (a == REG_TAC) begin
				shadow_tac <= wdata[2:0];
				if (wdata[2])
					timer_used <= 1'b1;
			end
			if (a == REG_IF)
				shadow_if <= wdata[4:0];
			if (a == REG_IE)
				shadow_ie <= wdata;
		end
	end

	always @(posedge clk) begin
		pend_valid <= rd && !rst;
		pend_addr  <= a;
		pend_exp   <= ref_read(a);
		pend_mask  <= checked_bits(a);
	end

	always @(negedge clk) begin
		if (pend_valid) begin
			last_rdata = rdata;
			if ((rdata & pend_mask) !== (pend_exp & pend_mask)) begin
				data_errors++;
				$display("[FAIL] %0t rdata at %h: expected %h, got %h",
					$time, pend_addr, pend_exp, rdata);
			end
			reads_checked++;
		end
		if (!rst && (rd || wr)) begin
			exp_ext = expect_ext(a);
			if (ext_cs !== exp_ext || ext_rd !== (exp_ext && rd) || ext_wr !== (exp_ext && wr)) begin
				strobe_errors++;
				$display("[FAIL] %0t ext_cs/ext_rd/ext_wr at %h: expected %b%b%b, got %b%b%b",
					$time, a, exp_ext, exp_ext && rd, exp_ext && wr, ext_cs, ext_rd, ext_wr);
			end
		end
	end

	initial begin
		wait (cycles >= 20000); // Sum of test lengths plus margin
		$display("Timeout: run did not finish within %0d cycles", cycles);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		logic [7:0]  val;
		logic [15:0] addr;
		int          start;
		logic        seen;
		a         = '0;
		wdata     = '0;
		wr        = 1'b0;
		rd        = 1'b0;
		ext_rdata = '0;
		lfsr      = 32'h1c854175;
		do @(posedge clk); while (rst);

		for (int i = 0; i < 256; i++)
			load_byte(16'(i), val);

		for (int i = 0; i < 300; i++) begin
			addr = HRAM_BASE + 16'(take_bits(7) % 127);
			if (take_bits(1) != 0)
				store_byte(addr, 8'(take_bits(8)));
			else
				load_byte(addr, val);
		end
		for (int i = 0; i < 127; i++)
			load_byte(HRAM_BASE + 16'(i), val);
		for (int i = 0; i < 48; i++)
			load_byte(16'hff00 | take_bits(7), val); // FF00-FF7F

		store_byte(REG_BOOT_OFF, 8'hfe);
		for (int i = 0; i < 16; i++)
			load_byte(take_bits(8), val);
		store_byte(REG_BOOT_OFF, 8'h01);
		for (int i = 0; i < 16; i++)
			load_byte(take_bits(8), val);
		store_byte(REG_BOOT_OFF, 8'h00);
		for (int i = 0; i < 16; i++)
			load_byte(take_bits(8), val);
		for (int i = 0; i < 32; i++) begin
			addr = take_bits(16) & 16'hfeff; // Never FFxx
			if (take_bits(1) != 0)
				store_byte(addr, 8'(take_bits(8)));
			else
				load_byte(addr, val);
		end

		for (int i = 0; i < 8; i++) begin
			store_byte(REG_TMA, 8'(take_bits(8)));
			load_byte(REG_TMA, val);
			store_byte(REG_TAC, 8'(take_bits(8)));
			load_byte(REG_TAC, val);
		end
		store_byte(REG_TAC, 8'h00);
		store_byte(REG_DIV, 8'h5a);
		load_byte(REG_DIV, val);
		if (val > 8'h01) begin
			other_errors++;
			$display("[FAIL] %0t div: expected 00 or 01, got %h", $time, val);
		end

		store_byte(REG_TMA, 8'hfc);
		store_byte(REG_TIMA, 8'hfc); // Four ticks to overflow
		store_byte(REG_IF, 8'h00);
		store_byte(REG_TAC, 8'h05);
		start = cycles;
		seen  = 1'b0;
		while (!seen && cycles - start < 400) begin
			load_byte(REG_IF, val);
			seen = val[INT_TIMER];
		end
		if (!seen) begin
			other_errors++;
			$display("Timer interrupt flag was not set within 400 cycles");
		end
		load_byte(REG_TIMA, val);
		if (val < 8'hfc) begin
			other_errors++;
			$display("[FAIL] %0t tima: expected fc or above, got %h", $time, val);
		end
		for (int i = 0; i < 8; i++) begin
			store_byte(REG_IE, 8'(take_bits(8)));
			load_byte(REG_IE, val);
			store_byte(REG_IF, 8'(take_bits(8)));
			load_byte(REG_IF, val);
		end

		$display("%0d reads checked: %0d data errors, %0d strobe errors, %0d other errors",
			reads_checked, data_errors, strobe_errors, other_errors);
		if (data_errors + strobe_errors + other_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
verilog/sys_pkg.sv
verilog/cpu_port_if.sv
verilog/sys_decode.sv
verilog/hram.sv
verilog/boot_rom.sv
verilog/timer.sv
verilog/int_flags.sv
verilog/sys_top.sv
tests/tb_clock.sv
tests/sys_assertions.sv
tests/sys_tb.sv

// File: run.sh
#!/bin/sh
set -e

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module sys_tb -o sys_sim

status=0
./obj_dir/sys_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
grep -q "TESTS PASSED" sim.log

// File: verilog/boot.hex
// Boot ROM image, 16 bytes per line
// Line n holds addresses n*16 to n*16+15
00 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0
01 11 21 31 41 51 61 71 81 91 a1 b1 c1 d1 e1 f1
02 12 22 32 42 52 62 72 82 92 a2 b2 c2 d2 e2 f2
03 13 23 33 43 53 63 73 83 93 a3 b3 c3 d3 e3 f3
04 14 24 34 44 54 64 74 84 94 a4 b4 c4 d4 e4 f4
05 15 25 35 45 55 65 75 85 95 a5 b5 c5 d5 e5 f5
06 16 26 36 46 56 66 76 86 96 a6 b6 c6 d6 e6 f6
07 17 27 37 47 57 67 77 87 97 a7 b7 c7 d7 e7 f7
08 18 28 38 48 58 68 78 88 98 a8 b8 c8 d8 e8 f8
09 19 29 39 49 59 69 79 89 99 a9 b9 c9 d9 e9 f9
0a 1a 2a 3a 4a 5a 6a 7a 8a 9a aa ba ca da ea fa
0b 1b 2b 3b 4b 5b 6b 7b 8b 9b ab bb cb db eb fb
0c 1c 2c 3c 4c 5c 6c 7c 8c 9c ac bc cc dc ec fc
0d 1d 2d 3d 4d 5d 6d 7d 8d 9d ad bd cd dd ed fd
0e 1e 2e 3e 4e 5e 6e 7e 8e 9e ae be ce de ee fe
0f 1f 2f 3f 4f 5f 6f 7f 8f 9f af bf cf df ef ff
